/* data_sram.sv */
`timescale 1ns/1ps

module data_sram #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic            clk_i,
  input  logic            rst_ni,

  input  logic            data_req_i,
  output logic            data_gnt_o,
  input  lsu_pkg::word_t  data_addr_i,
  input  logic            data_we_i,
  input  lsu_pkg::be_t    data_be_i,
  input  lsu_pkg::word_t  data_wdata_i,
  output logic            data_rvalid_o,
  output lsu_pkg::word_t  data_rdata_o,
  output logic            data_err_o,

  input  logic            gnt_block_i   // another master owns the memory this cycle
);

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  lsu_pkg::word_t   mem [MEM_WORDS];
  logic [IDX_W-1:0] idx;
  logic             in_range;
  logic             access;
  logic             rvalid_q;
  logic             err_q;
  lsu_pkg::word_t   rdata_q;

  assign idx      = data_addr_i[2 +: IDX_W];
  assign in_range = {2'b00, data_addr_i[31:2]} < MEM_WORDS;

  // grant in the request cycle unless blocked
  assign data_gnt_o = data_req_i && !gnt_block_i;
  assign access     = data_gnt_o;

  // byte lane writes, old word returned on every access
  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= in_range ? mem[idx] : '0;
      if (data_we_i && in_range) begin
        for (int i = 0; i < lsu_pkg::BYTES_PER_WORD; i++) begin
          if (data_be_i[i]) begin
            mem[idx][8*i +: 8] <= data_wdata_i[8*i +: 8];
          end
        end
      end
    end
  end

  // response exactly one cycle after grant
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= access;
      err_q    <= access && !in_range;  // out of range, write already dropped
    end
  end

  assign data_rvalid_o = rvalid_q;
  assign data_err_o    = err_q;
  assign data_rdata_o  = rdata_q;

endmodule

/* files.f */
lsu_pkg.sv
lsu_issue.sv
load_store_unit.sv
data_sram.sv
lsu_top.sv
lsu_top_assert.sv
tb_lsu_top.sv

/* load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // data bus
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic                   data_err_i,
  output lsu_pkg::word_t         data_addr_o,
  output logic                   data_we_o,
  output lsu_pkg::be_t           data_be_o,
  output lsu_pkg::word_t         data_wdata_o,
  input  lsu_pkg::word_t         data_rdata_i,

  // access from the sequencer
  input  logic                   data_req_ex_i,
  input  logic                   data_we_ex_i,
  input  lsu_pkg::data_type_t    data_type_ex_i,
  input  lsu_pkg::sign_ext_t     data_sign_ext_ex_i,
  input  lsu_pkg::word_t         operand_a_ex_i,
  input  lsu_pkg::word_t         operand_b_ex_i,
  input  lsu_pkg::word_t         data_wdata_ex_i,
  input  logic                   data_misaligned_ex_i,  // this is the second access
  input  logic                   ex_valid_i,            // this is the last access
  output logic                   data_misaligned_o,     // a second access is needed
  output logic                   lsu_ready_ex_o,

  // response port
  output logic                   rsp_valid_o,
  output lsu_pkg::word_t         rsp_rdata_o,
  output logic                   rsp_err_o,
  output logic                   busy_o
);

  lsu_pkg::word_t  addr_sum;
  lsu_pkg::shamt_t shamt;
  lsu_pkg::be_t    base_be;
  logic [7:0]      be_wide;   // mask shifted into two words
  logic [63:0]     wdata_dbl;

  assign addr_sum = operand_a_ex_i + operand_b_ex_i;
  assign shamt    = addr_sum[1:0];  // same on both accesses, operand_a moves by 4

  always_comb begin
    data_addr_o = addr_sum;
    if (data_misaligned_ex_i) begin
      data_addr_o = {addr_sum[31:2], 2'b00};  // second access starts at lane 0
    end
  end

  // unshifted mask by size
  always_comb begin
    if (data_type_ex_i[1]) begin
      base_be = 4'b0001;
    end else if (data_type_ex_i[0]) begin
      base_be = 4'b0011;
    end else begin
      base_be = 4'b1111;
    end
  end

  // lanes past lane 3 belong to the next word
  assign be_wide   = {4'b0000, base_be} << shamt;
  assign data_be_o = data_misaligned_ex_i ? be_wide[7:4] : be_wide[3:0];

  // rotate left by the offset, spilled bytes wrap to the low lanes
  assign wdata_dbl    = {2{data_wdata_ex_i}} << {shamt, 3'b000};
  assign data_wdata_o = wdata_dbl[63:32];
  assign data_we_o    = data_we_ex_i;

  // only the first access of a command can be split
  always_comb begin
    data_misaligned_o = 1'b0;
    if (data_req_ex_i && !data_misaligned_ex_i) begin
      data_misaligned_o = (data_type_ex_i == lsu_pkg::TYPE_WORD && shamt != 2'b00) ||
                          (data_type_ex_i == lsu_pkg::TYPE_HALF && shamt == 2'b11);
    end
  end

  // outstanding rvalid tracking, the ExStall states are mid-command
  typedef enum logic [1:0] {
    Idle, WaitRValid, WaitRValidExStall, IdleExStall
  } req_state_e;

  req_state_e state_d, state_q;
  logic       req_allowed;
  logic       granted;

  always_comb begin
    req_allowed = 1'b0;
    unique case (state_q)
      Idle, IdleExStall:             req_allowed = 1'b1;
      WaitRValid, WaitRValidExStall: req_allowed = data_rvalid_i;  // rvalid frees the slot
      default:                       req_allowed = 1'b0;
    endcase
  end

  assign data_req_o     = data_req_ex_i && req_allowed;
  assign granted        = data_req_o && data_gnt_i;
  assign lsu_ready_ex_o = !data_req_ex_i || granted;

  always_comb begin
    state_d = state_q;
    if (granted) begin
      state_d = ex_valid_i ? WaitRValid : WaitRValidExStall;
    end else begin
      unique case (state_q)
        WaitRValid: begin
          if (data_rvalid_i) begin
            state_d = Idle;
          end
        end
        WaitRValidExStall: begin
          if (data_rvalid_i) begin
            state_d = IdleExStall;  // second access held off by the bus
          end
        end
        IdleExStall: begin
          if (!data_req_ex_i) begin
            state_d = Idle;
          end
        end
        default: state_d = Idle;
      endcase
    end
  end

  assign busy_o = (state_q != Idle) || data_req_o;

  // how the next response fits into the word
  typedef enum logic [1:0] {
    RespRegular,     // whole access in one word
    RespMisaligned,  // lower part of a split access
    RespAligned      // upper part of a split access
  } resp_state_e;

  resp_state_e         resp_state_d, resp_state_q;
  lsu_pkg::be_t        mask_q;      // request properties latched at grant
  lsu_pkg::shamt_t     shamt_q;
  lsu_pkg::data_type_t type_q;
  lsu_pkg::sign_ext_t  sign_ext_q;
  logic                last_q;
  logic                err_q;       // errors of earlier accesses in this command
  logic                err_any;
  logic                ext_bit;
  lsu_pkg::word_t      rd_masked, merged, extended, rsp_word;
  lsu_pkg::word_t      part_q;      // lower part of a split load
  lsu_pkg::word_t      rsp_q;

  always_comb begin
    resp_state_d = resp_state_q;
    if (granted && data_misaligned_o) begin
      resp_state_d = RespMisaligned;  // wins over an rvalid of the previous command
    end else if (data_rvalid_i) begin
      resp_state_d = (resp_state_q == RespMisaligned) ? RespAligned : RespRegular;
    end
  end

  always_comb begin
    rd_masked = data_rdata_i & {{8{mask_q[3]}}, {8{mask_q[2]}}, {8{mask_q[1]}}, {8{mask_q[0]}}};
    if (resp_state_q == RespAligned) begin
      // spilled bytes sit above the ones from the first word
      merged = (rd_masked << (6'd32 - {1'b0, shamt_q, 3'b000})) | part_q;
    end else begin
      merged = rd_masked >> {shamt_q, 3'b000};
    end

    unique case (sign_ext_q)
      lsu_pkg::EXT_ZERO: ext_bit = 1'b0;
      lsu_pkg::EXT_ONES: ext_bit = 1'b1;
      default:           ext_bit = type_q[1] ? merged[7] : merged[15];
    endcase

    if (type_q[1]) begin
      extended = {{24{ext_bit}}, merged[7:0]};
    end else if (type_q[0]) begin
      extended = {{16{ext_bit}}, merged[15:0]};
    end else begin
      extended = merged;  // words need no fill
    end
  end

  assign err_any  = err_q || data_err_i;
  assign rsp_word = err_any ? '0 : extended;  // failed commands return zero

  assign rsp_valid_o = data_rvalid_i && last_q;
  assign rsp_rdata_o = rsp_valid_o ? rsp_word : rsp_q;
  assign rsp_err_o   = rsp_valid_o && err_any;

  always_ff @(posedge clk_i) begin
    if (data_rvalid_i) begin
      part_q <= merged;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= Idle;
      resp_state_q <= RespRegular;
      mask_q       <= '0;
      shamt_q      <= '0;
      type_q       <= '0;
      sign_ext_q   <= '0;
      last_q       <= 1'b0;
      err_q        <= 1'b0;
      rsp_q        <= '0;
    end else begin
      state_q      <= state_d;
      resp_state_q <= resp_state_d;
      if (granted) begin
        mask_q     <= data_be_o;
        shamt_q    <= shamt;
        type_q     <= data_type_ex_i;
        sign_ext_q <= data_sign_ext_ex_i;
        last_q     <= ex_valid_i;
      end
      if (data_rvalid_i) begin
        err_q <= last_q ? 1'b0 : err_any;  // clear once the command answers
      end
      if (rsp_valid_o) begin
        rsp_q <= rsp_word;
      end
    end
  end

endmodule

/* lsu_issue.sv */
`timescale 1ns/1ps

module lsu_issue (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // command port, held stable by the outside until cmd_done_o
  input  logic                   cmd_req_i,
  input  logic                   cmd_we_i,
  input  lsu_pkg::data_type_t    cmd_type_i,
  input  lsu_pkg::sign_ext_t     cmd_sign_ext_i,
  input  lsu_pkg::word_t         cmd_base_i,
  input  lsu_pkg::word_t         cmd_offset_i,
  input  lsu_pkg::word_t         cmd_wdata_i,
  output logic                   cmd_done_o,      // last access of the command granted

  // handshake back from lsu and bus
  input  logic                   lsu_ready_ex_i,
  input  logic                   data_gnt_i,
  input  logic                   data_misaligned_i,  // first access needs a second one

  // access towards the lsu
  output logic                   data_req_ex_o,
  output logic                   data_we_ex_o,
  output lsu_pkg::data_type_t    data_type_ex_o,
  output lsu_pkg::sign_ext_t     data_sign_ext_ex_o,
  output lsu_pkg::word_t         operand_a_ex_o,
  output lsu_pkg::word_t         operand_b_ex_o,
  output lsu_pkg::word_t         data_wdata_ex_o,
  output logic                   data_misaligned_ex_o,
  output logic                   ex_valid_o          // current access is the last one
);

  // which access of the held command is on the bus
  typedef enum logic {
    First,   // single access, or lower word of a split access
    Second   // upper word of a split access
  } issue_state_e;

  issue_state_e state_d, state_q;

  logic acc_taken;  // current access accepted by lsu and bus

  // command fields go straight through, the outside keeps them stable
  assign data_req_ex_o      = cmd_req_i;
  assign data_we_ex_o       = cmd_we_i;
  assign data_type_ex_o     = cmd_type_i;
  assign data_sign_ext_ex_o = cmd_sign_ext_i;
  assign data_wdata_ex_o    = cmd_wdata_i;  // lsu rotates it for both halves
  assign operand_b_ex_o     = cmd_offset_i;

  // second access moves one word up, lsu clears the low address bits
  always_comb begin
    operand_a_ex_o = cmd_base_i;
    if (state_q == Second) begin
      operand_a_ex_o = cmd_base_i + 32'd4;
    end
  end

  assign data_misaligned_ex_o = (state_q == Second);

  // a first access is the last one unless it spills into the next word
  always_comb begin
    if (state_q == Second) begin
      ex_valid_o = 1'b1;
    end else begin
      ex_valid_o = !data_misaligned_i;
    end
  end

  assign acc_taken  = data_req_ex_o && data_gnt_i && lsu_ready_ex_i;
  assign cmd_done_o = acc_taken && ex_valid_o;  // pulse on the final grant

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      First: begin
        if (acc_taken && data_misaligned_i) begin
          state_d = Second;  // lower part granted, upper part next cycle
        end
      end
      Second: begin
        if (acc_taken) begin
          state_d = First;   // command complete
        end
      end
      default: state_d = First;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= First;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* lsu_pkg.sv */
package lsu_pkg;

  // data word or byte address
  typedef logic [31:0] word_t;

  // one enable bit per byte lane, lane 0 is bits 7:0
  typedef logic [3:0] be_t;

  // byte offset inside a word
  typedef logic [1:0] shamt_t;

  // access size, upper bit set means byte
  typedef logic [1:0] data_type_t;

  // extension of sub-word loads
  typedef logic [1:0] sign_ext_t;

  // access size encodings
  localparam data_type_t TYPE_WORD = 2'b00;
  localparam data_type_t TYPE_HALF = 2'b01;
  localparam data_type_t TYPE_BYTE = 2'b10;  // 2'b11 is a byte as well

  // extension encodings
  localparam sign_ext_t EXT_ZERO = 2'b00;  // fill upper bits with zeros
  localparam sign_ext_t EXT_SIGN = 2'b01;  // copy top bit of the loaded byte or half word
  localparam sign_ext_t EXT_ONES = 2'b10;  // fill upper bits with ones

  // byte lanes per word
  localparam int unsigned BYTES_PER_WORD = 4;

endpackage

/* lsu_top.sv */
`timescale 1ns/1ps

module lsu_top #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // command port
  input  logic                   cmd_req_i,
  input  logic                   cmd_we_i,
  input  lsu_pkg::data_type_t    cmd_type_i,
  input  lsu_pkg::sign_ext_t     cmd_sign_ext_i,
  input  lsu_pkg::word_t         cmd_base_i,
  input  lsu_pkg::word_t         cmd_offset_i,
  input  lsu_pkg::word_t         cmd_wdata_i,
  output logic                   cmd_done_o,

  // response port
  output logic                   rsp_valid_o,
  output lsu_pkg::word_t         rsp_rdata_o,
  output logic                   rsp_err_o,
  output logic                   busy_o,

  input  logic                   gnt_block_i
);

  // sequencer to lsu
  logic                data_req_ex, data_we_ex, data_misaligned_ex, ex_valid;
  lsu_pkg::data_type_t data_type_ex;
  lsu_pkg::sign_ext_t  data_sign_ext_ex;
  lsu_pkg::word_t      operand_a_ex, operand_b_ex, data_wdata_ex;
  logic                lsu_ready_ex, data_misaligned;

  // lsu to memory
  logic                data_req, data_gnt, data_we, data_rvalid, data_err;
  lsu_pkg::word_t      data_addr, data_wdata, data_rdata;
  lsu_pkg::be_t        data_be;

  lsu_issue u_issue (
    .clk_i, .rst_ni,
    .cmd_req_i, .cmd_we_i, .cmd_type_i, .cmd_sign_ext_i,
    .cmd_base_i, .cmd_offset_i, .cmd_wdata_i, .cmd_done_o,
    .lsu_ready_ex_i       (lsu_ready_ex),
    .data_gnt_i           (data_gnt),
    .data_misaligned_i    (data_misaligned),
    .data_req_ex_o        (data_req_ex),
    .data_we_ex_o         (data_we_ex),
    .data_type_ex_o       (data_type_ex),
    .data_sign_ext_ex_o   (data_sign_ext_ex),
    .operand_a_ex_o       (operand_a_ex),
    .operand_b_ex_o       (operand_b_ex),
    .data_wdata_ex_o      (data_wdata_ex),
    .data_misaligned_ex_o (data_misaligned_ex),
    .ex_valid_o           (ex_valid)
  );

  load_store_unit u_lsu (
    .clk_i, .rst_ni,
    .data_req_o (data_req), .data_gnt_i (data_gnt), .data_rvalid_i (data_rvalid),
    .data_err_i (data_err), .data_addr_o (data_addr), .data_we_o (data_we),
    .data_be_o (data_be), .data_wdata_o (data_wdata), .data_rdata_i (data_rdata),
    .data_req_ex_i (data_req_ex), .data_we_ex_i (data_we_ex),
    .data_type_ex_i (data_type_ex), .data_sign_ext_ex_i (data_sign_ext_ex),
    .operand_a_ex_i (operand_a_ex), .operand_b_ex_i (operand_b_ex),
    .data_wdata_ex_i (data_wdata_ex), .data_misaligned_ex_i (data_misaligned_ex),
    .ex_valid_i (ex_valid), .data_misaligned_o (data_misaligned),
    .lsu_ready_ex_o (lsu_ready_ex),
    .rsp_valid_o, .rsp_rdata_o, .rsp_err_o, .busy_o
  );

  data_sram #(
    .MEM_WORDS (MEM_WORDS)
  ) u_sram (
    .clk_i, .rst_ni,
    .data_req_i (data_req), .data_gnt_o (data_gnt), .data_addr_i (data_addr),
    .data_we_i (data_we), .data_be_i (data_be), .data_wdata_i (data_wdata),
    .data_rvalid_o (data_rvalid), .data_rdata_o (data_rdata), .data_err_o (data_err),
    .gnt_block_i
  );

endmodule

/* lsu_top_assert.sv */
`timescale 1ns/1ps

module lsu_top_assert (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_i,
  input  logic           gnt_i,
  input  logic           rvalid_i,
  input  lsu_pkg::word_t addr_i,
  input  logic [1:0]     req_state_i  // Idle is the first enum member, encoded zero
);

  // request stays up with the same address until granted
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && !gnt_i |=> req_i && $stable(addr_i))
    else $error("data_req dropped or data_addr changed before grant");

  // every rvalid belongs to a grant, so never with nothing outstanding
  rvalid_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> req_state_i != 2'd0)
    else $error("data_rvalid while the request FSM is Idle");

  addr_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> !$isunknown(addr_i))
    else $error("data_addr unknown during a request");

endmodule

bind load_store_unit lsu_top_assert u_bus_assert (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_i       (data_req_o),
  .gnt_i       (data_gnt_i),
  .rvalid_i    (data_rvalid_i),
  .addr_i      (data_addr_o),
  .req_state_i (state_q)
);

/* run.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it and look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module tb_lsu_top \
    -f files.f --Mdir obj_dir -o sim_lsu; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_lsu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

/* tb_lsu_top.sv */
`timescale 1ns/1ps

module tb_lsu_top;

  localparam int unsigned MEM_WORDS       = 256;
  localparam int unsigned MEM_BYTES       = 4 * MEM_WORDS;
  localparam int unsigned BP_CMDS         = 60;
  // fill, aligned, sub-word, misaligned, random, error commands
  localparam int unsigned NUM_CMDS        = 64 + 16 + 43 + 17 + BP_CMDS + 6;
  localparam int unsigned WATCHDOG_CYCLES = NUM_CMDS * 20 + 100;
  localparam int unsigned SAMPLE_DLY      = 10;  // after the falling edge, outputs settled

  logic                clk_i, rst_ni, gnt_block_i;
  logic                cmd_req_i, cmd_we_i, cmd_done_o;
  lsu_pkg::data_type_t cmd_type_i;
  lsu_pkg::sign_ext_t  cmd_sign_ext_i;
  lsu_pkg::word_t      cmd_base_i, cmd_offset_i, cmd_wdata_i;
  logic                rsp_valid_o, rsp_err_o, busy_o;
  lsu_pkg::word_t      rsp_rdata_o;

  logic [7:0] ref_mem [MEM_BYTES];  // byte mirror of data_sram
  logic       block_en;             // random grant blocking on/off

  lsu_top #(.MEM_WORDS (MEM_WORDS)) dut (.*);

  always #50 clk_i = ~clk_i;  // 100 ns period

  function automatic int unsigned access_bytes(lsu_pkg::data_type_t typ);
    if (typ[1]) return 1;  // upper bit set is a byte
    if (typ[0]) return 2;
    return 4;
  endfunction

  // 1 KiB reference, ten address bits
  function automatic logic [9:0] byte_idx(lsu_pkg::word_t addr, int unsigned k);
    lsu_pkg::word_t a;
    a = addr + k;
    return a[9:0];
  endfunction

  function automatic lsu_pkg::word_t fill_word(lsu_pkg::word_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5ac3_0f1e;
  endfunction

  // little-endian gather, then fill above the loaded bytes
  function automatic lsu_pkg::word_t expected_load(lsu_pkg::word_t addr,
      lsu_pkg::data_type_t typ, lsu_pkg::sign_ext_t ext);
    lsu_pkg::word_t val;
    int unsigned    n;
    logic           fill;
    val = '0;
    n   = access_bytes(typ);
    for (int unsigned k = 0; k < n; k++) begin
      val = val | ({24'h0, ref_mem[byte_idx(addr, k)]} << (8 * k));
    end
    if (ext == lsu_pkg::EXT_ZERO) fill = 1'b0;
    else if (ext == lsu_pkg::EXT_ONES) fill = 1'b1;
    else fill = (n == 1) ? val[7] : val[15];  // top bit of the loaded part
    if (n == 1) val = val | {{24{fill}}, 8'h00};
    else if (n == 2) val = val | {{16{fill}}, 16'h0000};
    return val;
  endfunction

  task automatic store_ref(lsu_pkg::word_t addr, lsu_pkg::data_type_t typ,
      lsu_pkg::word_t wdata);
    lsu_pkg::word_t sh;
    for (int unsigned k = 0; k < access_bytes(typ); k++) begin
      sh = wdata >> (8 * k);
      ref_mem[byte_idx(addr, k)] = sh[7:0];
    end
  endtask

  task automatic report_error(string msg);
    $display("ERR %0t: %s", $time, msg);
    $display("tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic drive_block();
    lsu_pkg::word_t r;
    r = $urandom;
    gnt_block_i = block_en & r[0];  // roughly every other cycle blocked
  endtask

  // one command through the sequencer, result checked against the mirror
  task automatic run_cmd(logic we, lsu_pkg::data_type_t typ, lsu_pkg::sign_ext_t ext,
      lsu_pkg::word_t base, lsu_pkg::word_t offset, lsu_pkg::word_t wdata);
    lsu_pkg::word_t addr, exp_rdata;
    logic           exp_err;
    addr      = base + offset;
    exp_err   = (addr + access_bytes(typ) - 1) >= MEM_BYTES;  // any byte past the memory
    exp_rdata = exp_err ? '0 : expected_load(addr, typ, ext);
    @(negedge clk_i);
    assert (!busy_o) else report_error("busy_o high with no command pending");
    cmd_req_i      = 1'b1;
    cmd_we_i       = we;
    cmd_type_i     = typ;
    cmd_sign_ext_i = ext;
    cmd_base_i     = base;
    cmd_offset_i   = offset;
    cmd_wdata_i    = wdata;
    drive_block();
    #SAMPLE_DLY;
    while (!cmd_done_o) begin
      assert (!rsp_valid_o) else report_error("rsp_valid_o before cmd_done_o");
      assert (busy_o) else report_error("busy_o low while a command is requested");
      @(negedge clk_i);
      drive_block();
      #SAMPLE_DLY;
    end
    assert (!rsp_valid_o) else report_error("rsp_valid_o together with cmd_done_o");
    @(negedge clk_i);
    cmd_req_i = 1'b0;  // command taken, release it
    drive_block();
    #SAMPLE_DLY;
    assert (rsp_valid_o) else report_error("rsp_valid_o not one cycle after cmd_done_o");
    assert (rsp_err_o == exp_err)
      else report_error($sformatf("addr %h err %b, expected %b", addr, rsp_err_o, exp_err));
    if (!we || exp_err) begin
      assert (rsp_rdata_o == exp_rdata)
        else report_error($sformatf("addr %h type %0d ext %0d read %h, expected %h",
                                    addr, typ, ext, rsp_rdata_o, exp_rdata));
    end
    if (we && !exp_err) store_ref(addr, typ, wdata);
  endtask

  // random base/offset split of the same address exercises the adder
  task automatic issue_at(logic we, lsu_pkg::data_type_t typ, lsu_pkg::sign_ext_t ext,
      lsu_pkg::word_t addr, lsu_pkg::word_t wdata);
    lsu_pkg::word_t offset;
    offset = $urandom;
    run_cmd(we, typ, ext, addr - offset, offset, wdata);
  endtask

  task automatic check_reset_outputs();
    #SAMPLE_DLY;
    assert (!rsp_valid_o && !cmd_done_o && !busy_o && rsp_err_o == 1'b0)
      else report_error("control outputs not low after reset");
    assert (rsp_rdata_o == '0) else report_error("rsp_rdata_o not zero after reset");
  endtask

  task automatic fill_memory();
    for (int unsigned w = 0; w < 64; w++) begin
      issue_at(1'b1, lsu_pkg::TYPE_WORD, lsu_pkg::EXT_ZERO, w * 4, fill_word(w * 4));
    end
  endtask

  task automatic aligned_word_round_trip();
    lsu_pkg::word_t addrs [8];
    for (int i = 0; i < 8; i++) begin
      addrs[i] = $urandom_range(63, 0) << 2;
      issue_at(1'b1, lsu_pkg::TYPE_WORD, lsu_pkg::EXT_ZERO, addrs[i], $urandom);
    end
    for (int i = 0; i < 8; i++) begin
      issue_at(1'b0, lsu_pkg::TYPE_WORD, lsu_pkg::EXT_ZERO, addrs[i], '0);
    end
  endtask

  task automatic subword_access();
    // bytes fe 01 80 7f give both sign values at every offset
    issue_at(1'b1, lsu_pkg::TYPE_WORD, lsu_pkg::EXT_ZERO, 32'h80, 32'h7f80_01fe);
    for (int unsigned off = 0; off < 4; off++) begin
      for (int unsigned e = 0; e < 4; e++) begin
        issue_at(1'b0, e[0] ? lsu_pkg::TYPE_BYTE : 2'b11, e[1:0], 32'h80 + off, '0);
      end
    end
    for (int unsigned off = 0; off < 3; off++) begin
      for (int unsigned e = 0; e < 4; e++) begin
        issue_at(1'b0, lsu_pkg::TYPE_HALF, e[1:0], 32'h80 + off, '0);
      end
    end
    for (int unsigned off = 0; off < 4; off++) begin
      issue_at(1'b1, lsu_pkg::TYPE_BYTE, lsu_pkg::EXT_ZERO, 32'h90 + off, $urandom);
      issue_at(1'b0, lsu_pkg::TYPE_WORD, lsu_pkg::EXT_ZERO, 32'h90, '0);  // other lanes kept
    end
    for (int unsigned off = 0; off < 3; off++) begin
      issue_at(1'b1, lsu_pkg::TYPE_HALF, lsu_pkg::EXT_ZERO, 32'h94 + off, $urandom);
      issue_at(1'b0, lsu_pkg::TYPE_WORD, lsu_pkg::EXT_ZERO, 32'h94, '0);
    end
  endtask

  task automatic split_access();
    for (int unsigned off = 1; off < 4; off++) begin
      issue_at(1'b1, lsu_pkg::TYPE_WORD, lsu_pkg::EXT_ZERO, 32'ha0 + off, $urandom);
      issue_at(1'b0, lsu_pkg::TYPE_WORD, lsu_pkg::EXT_SIGN, 32'ha0 + off, '0);
      issue_at(1'b0, lsu_pkg::TYPE_WORD, lsu_pkg::EXT_ZERO, 32'ha0, '0);
      issue_at(1'b0, lsu_pkg::TYPE_WORD, lsu_pkg::EXT_ZERO, 32'ha4, '0);
    end
    issue_at(1'b1, lsu_pkg::TYPE_HALF, lsu_pkg::EXT_ZERO, 32'hb3, $urandom);
    issue_at(1'b0, lsu_pkg::TYPE_HALF, lsu_pkg::EXT_SIGN, 32'hb3, '0);
    issue_at(1'b0, lsu_pkg::TYPE_WORD, lsu_pkg::EXT_ZERO, 32'hb0, '0);
    issue_at(1'b0, lsu_pkg::TYPE_WORD, lsu_pkg::EXT_ZERO, 32'hb4, '0);
    issue_at(1'b0, lsu_pkg::TYPE_HALF, lsu_pkg::EXT_ONES, 32'hbb, '0);  // untouched fill data
  endtask

  task automatic random_blocked_grants();
    lsu_pkg::word_t r;
    block_en = 1'b1;
    for (int i = 0; i < BP_CMDS; i++) begin
      r = $urandom;
      // up to 4 bytes from address 251 stay inside the filled region
      issue_at(r[0], r[2:1], r[4:3], $urandom_range(251, 0), $urandom);
    end
    block_en = 1'b0;
  endtask

  task automatic out_of_range_access();
    issue_at(1'b0, lsu_pkg::TYPE_WORD, lsu_pkg::EXT_SIGN, 32'h400, '0);
    issue_at(1'b0, lsu_pkg::TYPE_BYTE, lsu_pkg::EXT_SIGN, 32'h2001, '0);
    issue_at(1'b1, lsu_pkg::TYPE_WORD, lsu_pkg::EXT_ZERO, 32'h400, 32'hdead_beef);
    issue_at(1'b0, lsu_pkg::TYPE_WORD, lsu_pkg::EXT_ZERO, 32'h0, '0);  // word index 0 aliases 0x400
    issue_at(1'b0, lsu_pkg::TYPE_WORD, lsu_pkg::EXT_ZERO, 32'h3fd, '0);  // upper half out of range
    issue_at(1'b0, lsu_pkg::TYPE_HALF, lsu_pkg::EXT_SIGN, 32'h3ff, '0);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired, the tests did not finish in time");
    $display("tests failed");
    $fatal(1, "timeout");
  end

  initial begin
    void'($urandom(32'hadbf43d6));
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    gnt_block_i    = 1'b0;
    block_en       = 1'b0;
    cmd_req_i      = 1'b0;
    cmd_we_i       = 1'b0;
    cmd_type_i     = '0;
    cmd_sign_ext_i = '0;
    cmd_base_i     = '0;
    cmd_offset_i   = '0;
    cmd_wdata_i    = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_reset_outputs();
    fill_memory();
    aligned_word_round_trip();
    subword_access();
    split_access();
    random_blocked_grants();
    out_of_range_access();
    $display("all tests passed");
    $finish;
  end

endmodule
